// File: src/readout_pkg.sv
`default_nettype none

package readout_pkg;

    localparam int NUM_FE = 2;

    // queue depths in 32-bit words
    localparam int FE_DEPTH      = 8;
    localparam int TRIG_DEPTH    = 4;
    localparam int OUT_DEPTH     = 16;
    localparam int OUT_NEAR_FULL = 12; // leaves room for words still in flight

    // bus windows
    localparam logic [15:0] ADDR_CTRL   = 16'h0000;
    localparam logic [15:0] ADDR_FIFO   = 16'h0100;
    localparam logic [15:0] WINDOW_SIZE = 16'h0100;

    // register offsets in the control window
    localparam logic [7:0] REG_CONTROL    = 8'd0;
    localparam logic [7:0] REG_STATUS     = 8'd1;
    localparam logic [7:0] REG_TRIG_COUNT = 8'd4; // 4 bytes, little-endian

    localparam int CTRL_FE_EN   = 0;
    localparam int CTRL_TRIG_EN = 1;

    localparam int ST_NOT_EMPTY = 0;
    localparam int ST_FULL      = 1;
    localparam int ST_NEAR_FULL = 2;
    localparam int ST_READ_ERR  = 3;

    typedef struct packed {
        logic        is_trig; // always 1
        logic [30:0] number;
    } trig_word_t;

    typedef struct packed {
        logic        is_trig; // always 0
        logic [3:0]  channel;
        logic [10:0] reserved;
        logic [15:0] data;
    } fe_word_t;

    // top bit tells the two apart
    typedef union packed {
        trig_word_t trig;
        fe_word_t   fe;
    } word_t;

endpackage

`default_nettype wire

// File: src/sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter int DEPTH     = 8,
    parameter int NEAR_FULL = 6
) (
    input  wire         bus_clk,
    input  wire         rst,
    input  wire         push,
    input  wire  [31:0] din,
    input  wire         pop,
    output logic [31:0] dout,
    output logic        empty,
    output logic        full,
    output logic        near_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push & ~full; // push into a full fifo is lost
    assign do_pop  = pop & ~empty;

    assign empty     = (count == '0);
    assign full      = (count == CW'(DEPTH));
    assign near_full = (count >= CW'(NEAR_FULL));
    assign dout      = mem[rd_ptr]; // head falls through

    always_ff @(posedge bus_clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/fe_word_fifo.sv
`default_nettype none

module fe_word_fifo
    import readout_pkg::*;
#(
    parameter int CHANNEL_ID = 0
) (
    input  wire         bus_clk,
    input  wire         rst,
    input  wire         fe_en,
    input  wire         raw_strobe,
    input  wire  [15:0] raw_data,
    input  wire         pop,
    output word_t       head,
    output logic        not_empty
);

    word_t fe_word;
    logic  full;
    logic  empty;
    logic  push;

    // strobe dropped when disabled or queue full
    assign push      = raw_strobe & fe_en & ~full;
    assign not_empty = ~empty;

    always_comb begin
        fe_word            = '0;
        fe_word.fe.is_trig = 1'b0;
        fe_word.fe.channel = 4'(CHANNEL_ID);
        fe_word.fe.data    = raw_data;
    end

    sync_fifo #(
        .DEPTH(FE_DEPTH),
        .NEAR_FULL(FE_DEPTH)
    ) ififo (
        .bus_clk(bus_clk),
        .rst(rst),
        .push(push),
        .din(fe_word),
        .pop(pop),
        .dout(head),
        .empty(empty),
        .full(full),
        .near_full()
    );

endmodule

`default_nettype wire

// File: src/trigger_word_gen.sv
`default_nettype none

module trigger_word_gen
    import readout_pkg::*;
(
    input  wire         bus_clk,
    input  wire         rst,
    input  wire         trig_en,
    input  wire         trigger_in,
    input  wire         veto,
    input  wire         pop,
    output word_t       head,
    output logic        not_empty,
    output logic        busy,
    output logic [31:0] trig_count
);

    logic  trig_d;
    logic  rise;
    logic  accept;
    logic  full;
    logic  empty;
    word_t trig_word;

    assign rise   = trigger_in & ~trig_d;
    assign accept = rise & trig_en & ~veto & ~full; // no count without a queue slot

    assign not_empty = ~empty;
    assign busy      = ~empty; // high until the last trigger word is taken

    // word carries the count after this trigger, first one is 1
    always_comb begin
        trig_word.trig.is_trig = 1'b1;
        trig_word.trig.number  = trig_count[30:0] + 31'd1;
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            trig_d     <= 1'b0;
            trig_count <= '0;
        end else begin
            trig_d <= trigger_in;
            if (accept)
                trig_count <= trig_count + 32'd1;
        end
    end

    sync_fifo #(
        .DEPTH(TRIG_DEPTH),
        .NEAR_FULL(TRIG_DEPTH)
    ) ififo (
        .bus_clk(bus_clk),
        .rst(rst),
        .push(accept),
        .din(trig_word),
        .pop(pop),
        .dout(head),
        .empty(empty),
        .full(full),
        .near_full()
    );

endmodule

`default_nettype wire

// File: src/word_arbiter.sv
`default_nettype none

module word_arbiter
    import readout_pkg::*;
(
    input  wire                      bus_clk,
    input  wire                      rst,
    input  wire word_t               trig_head,
    input  wire                      trig_not_empty,
    input  wire word_t [NUM_FE-1:0]  fe_head,
    input  wire        [NUM_FE-1:0]  fe_not_empty,
    input  wire                      near_full,
    output logic                     trig_pop,
    output logic       [NUM_FE-1:0]  fe_pop,
    output logic                     out_wr,
    output logic       [31:0]        out_word
);

    localparam int IDX_W = (NUM_FE > 1) ? $clog2(NUM_FE) : 1;

    logic [IDX_W-1:0] last_fe; // last granted channel
    logic [IDX_W-1:0] pick_idx;
    logic             fe_found;
    logic             fe_grant;
    int               cand;

    // walk backwards so the channel right after last_fe wins
    always_comb begin
        fe_found = 1'b0;
        pick_idx = last_fe;
        cand     = 0;
        for (int i = NUM_FE; i >= 1; i--) begin
            cand = (int'(last_fe) + i) % NUM_FE;
            if (fe_not_empty[cand]) begin
                fe_found = 1'b1;
                pick_idx = IDX_W'(cand);
            end
        end
    end

    assign trig_pop = ~near_full & trig_not_empty; // trigger words first
    assign fe_grant = ~near_full & ~trig_not_empty & fe_found;

    always_comb begin
        fe_pop           = '0;
        fe_pop[pick_idx] = fe_grant;
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            out_wr  <= 1'b0;
            last_fe <= IDX_W'(NUM_FE - 1); // channel 0 goes first
        end else begin
            out_wr <= trig_pop | fe_grant;
            if (fe_grant)
                last_fe <= pick_idx;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (trig_pop)
            out_word <= trig_head;
        else if (fe_grant)
            out_word <= fe_head[pick_idx];
    end

endmodule

`default_nettype wire

// File: src/out_fifo.sv
`default_nettype none

module out_fifo
    import readout_pkg::*;
(
    input  wire         bus_clk,
    input  wire         rst,
    input  wire         wr,
    input  wire  [31:0] word_in,
    input  wire         rd,
    input  wire  [1:0]  byte_sel,
    input  wire         clear_err,
    output logic [7:0]  byte_out,
    output logic        not_empty,
    output logic        full,
    output logic        near_full,
    output logic        read_err
);

    logic [31:0] head;
    logic        empty;
    logic        pop;

    assign not_empty = ~empty;

    // byte 3 is the last one of a word
    assign pop = rd & (byte_sel == 2'd3) & ~empty;

    // low byte at offset 0, nothing to show when empty
    assign byte_out = empty ? 8'h00 : head[8*byte_sel +: 8];

    // sticky until the host clears it
    always_ff @(posedge bus_clk) begin
        if (rst)
            read_err <= 1'b0;
        else if (rd & empty)
            read_err <= 1'b1;
        else if (clear_err)
            read_err <= 1'b0;
    end

    sync_fifo #(
        .DEPTH(OUT_DEPTH),
        .NEAR_FULL(OUT_NEAR_FULL)
    ) ififo (
        .bus_clk(bus_clk),
        .rst(rst),
        .push(wr),
        .din(word_in),
        .pop(pop),
        .dout(head),
        .empty(empty),
        .full(full),
        .near_full(near_full)
    );

endmodule

`default_nettype wire

// File: src/readout_ctrl.sv
`default_nettype none

module readout_ctrl
    import readout_pkg::*;
(
    input  wire         bus_clk,
    input  wire         rst,
    input  wire  [15:0] add,
    input  wire  [7:0]  data_in,
    input  wire         rd,
    input  wire         wr,
    input  wire  [31:0] trig_count,
    input  wire  [7:0]  fifo_byte_data,
    input  wire         fifo_not_empty,
    input  wire         fifo_full,
    input  wire         fifo_near_full,
    input  wire         fifo_read_err,
    output logic [7:0]  data_out,
    output logic        fe_en,
    output logic        trig_en,
    output logic        fifo_rd,
    output logic [1:0]  fifo_byte,
    output logic        clear_err
);

    logic [15:0] ctrl_off;
    logic [15:0] fifo_off;
    logic        ctrl_sel;
    logic        fifo_sel;
    logic [7:0]  ctrl_reg;
    logic [7:0]  status;
    logic [7:0]  reg_data;

    // offsets wrap below the base, so one compare per window
    assign ctrl_off = add - ADDR_CTRL;
    assign fifo_off = add - ADDR_FIFO;
    assign ctrl_sel = (ctrl_off < WINDOW_SIZE);
    assign fifo_sel = (fifo_off < WINDOW_SIZE);

    assign fifo_rd   = rd & fifo_sel;
    assign fifo_byte = fifo_off[1:0];
    assign clear_err = wr & ctrl_sel & (ctrl_off[7:0] == REG_STATUS); // any value clears

    assign fe_en   = ctrl_reg[CTRL_FE_EN];
    assign trig_en = ctrl_reg[CTRL_TRIG_EN];

    always_comb begin
        status               = '0;
        status[ST_NOT_EMPTY] = fifo_not_empty;
        status[ST_FULL]      = fifo_full;
        status[ST_NEAR_FULL] = fifo_near_full;
        status[ST_READ_ERR]  = fifo_read_err;
    end

    always_comb begin
        reg_data = 8'h00;
        if (ctrl_off[7:0] == REG_CONTROL)
            reg_data = ctrl_reg;
        else if (ctrl_off[7:0] == REG_STATUS)
            reg_data = status;
        else if (ctrl_off[7:2] == REG_TRIG_COUNT[7:2])
            reg_data = trig_count[8*ctrl_off[1:0] +: 8]; // little-endian
    end

    always_ff @(posedge bus_clk) begin
        if (rst)
            ctrl_reg <= '0;
        else if (wr && ctrl_sel && ctrl_off[7:0] == REG_CONTROL)
            ctrl_reg <= data_in;
    end

    // held between reads
    always_ff @(posedge bus_clk) begin
        if (rst) begin
            data_out <= '0;
        end else if (rd) begin
            if (fifo_sel)
                data_out <= fifo_byte_data;
            else if (ctrl_sel)
                data_out <= reg_data;
            else
                data_out <= 8'h00; // unmapped address
        end
    end

endmodule

`default_nettype wire

// File: src/readout_top.sv
`default_nettype none

module readout_top
    import readout_pkg::*;
(
    input  wire                    bus_clk,
    input  wire                    rst,
    input  wire [15:0]             add,
    input  wire [7:0]              data_in,
    input  wire                    rd,
    input  wire                    wr,
    input  wire [NUM_FE-1:0]       raw_strobe,
    input  wire [NUM_FE-1:0][15:0] raw_data,
    input  wire                    trigger_in,
    input  wire                    veto,
    output logic [7:0]             data_out,
    output logic                   busy
);

    wire                     fe_en;
    wire                     trig_en;
    wire                     fifo_rd;
    wire        [1:0]        fifo_byte;
    wire                     clear_err;
    wire        [7:0]        fifo_byte_data;
    wire                     fifo_not_empty;
    wire                     fifo_full;
    wire                     fifo_near_full; // also holds off the arbiter
    wire                     fifo_read_err;
    wire        [31:0]       trig_count;
    wire word_t              trig_head;
    wire                     trig_not_empty;
    wire                     trig_pop;
    wire word_t [NUM_FE-1:0] fe_head;
    wire        [NUM_FE-1:0] fe_not_empty;
    wire        [NUM_FE-1:0] fe_pop;
    wire                     out_wr;
    wire        [31:0]       out_word;

    readout_ctrl ireadout_ctrl (
        .bus_clk(bus_clk), .rst(rst), .add(add), .data_in(data_in), .rd(rd), .wr(wr),
        .trig_count(trig_count), .fifo_byte_data(fifo_byte_data),
        .fifo_not_empty(fifo_not_empty), .fifo_full(fifo_full),
        .fifo_near_full(fifo_near_full), .fifo_read_err(fifo_read_err),
        .data_out(data_out), .fe_en(fe_en), .trig_en(trig_en),
        .fifo_rd(fifo_rd), .fifo_byte(fifo_byte), .clear_err(clear_err)
    );

    for (genvar i = 0; i < NUM_FE; i++) begin : g_fe
        fe_word_fifo #(
            .CHANNEL_ID(i)
        ) ife_word_fifo (
            .bus_clk(bus_clk), .rst(rst), .fe_en(fe_en),
            .raw_strobe(raw_strobe[i]), .raw_data(raw_data[i]), .pop(fe_pop[i]),
            .head(fe_head[i]), .not_empty(fe_not_empty[i])
        );
    end

    trigger_word_gen itrigger_word_gen (
        .bus_clk(bus_clk), .rst(rst), .trig_en(trig_en), .trigger_in(trigger_in),
        .veto(veto), .pop(trig_pop), .head(trig_head), .not_empty(trig_not_empty),
        .busy(busy), .trig_count(trig_count)
    );

    word_arbiter iword_arbiter (
        .bus_clk(bus_clk), .rst(rst), .trig_head(trig_head),
        .trig_not_empty(trig_not_empty), .fe_head(fe_head), .fe_not_empty(fe_not_empty),
        .near_full(fifo_near_full), .trig_pop(trig_pop), .fe_pop(fe_pop),
        .out_wr(out_wr), .out_word(out_word)
    );

    out_fifo iout_fifo (
        .bus_clk(bus_clk), .rst(rst), .wr(out_wr), .word_in(out_word),
        .rd(fifo_rd), .byte_sel(fifo_byte), .clear_err(clear_err),
        .byte_out(fifo_byte_data), .not_empty(fifo_not_empty), .full(fifo_full),
        .near_full(fifo_near_full), .read_err(fifo_read_err)
    );

endmodule

`default_nettype wire

// File: dv/readout_assertions.sv
`default_nettype none

// watches the wires between trigger queue, arbiter and output fifo
module readout_assertions
    import readout_pkg::*;
(
    input wire              bus_clk,
    input wire              rst,
    input wire              trig_pop,
    input wire [NUM_FE-1:0] fe_pop,
    input wire              out_wr,
    input wire              out_full,
    input wire              busy
);

    // arbiter grants one source per cycle
    a_one_pop: assert property (@(posedge bus_clk) disable iff (rst)
        $onehot0({fe_pop, trig_pop}))
        else $error("more than one source queue popped in one cycle");

    a_no_wr_full: assert property (@(posedge bus_clk) disable iff (rst)
        out_wr |-> !out_full)
        else $error("arbiter wrote into a full output fifo");

    // busy only drops once the arbiter took the last trigger word
    a_busy: assert property (@(posedge bus_clk) disable iff (rst)
        $fell(busy) |-> $past(trig_pop))
        else $error("busy fell without a trigger queue pop");

endmodule

bind readout_top readout_assertions u_assertions (
    .bus_clk(bus_clk), .rst(rst), .trig_pop(trig_pop), .fe_pop(fe_pop),
    .out_wr(out_wr), .out_full(fifo_full), .busy(busy)
);

`default_nettype wire

// File: dv/readout_tb.sv
`default_nettype none

module readout_tb
    import readout_pkg::*;
();

    logic                    bus_clk;
    logic                    rst;
    logic [15:0]             add;
    logic [7:0]              data_in;
    logic                    rd;
    logic                    wr;
    logic [NUM_FE-1:0]       raw_strobe;
    logic [NUM_FE-1:0][15:0] raw_data;
    logic                    trigger_in;
    logic                    veto;
    wire  [7:0]              data_out;
    wire                     busy;

    logic [15:0] lfsr;
    logic [31:0] exp_q[$]; // words in the order the host should read them
    int          err_count;
    int          timeout_count;
    int          check_count;

    readout_top u_dut (
        .bus_clk(bus_clk), .rst(rst), .add(add), .data_in(data_in), .rd(rd), .wr(wr),
        .raw_strobe(raw_strobe), .raw_data(raw_data), .trigger_in(trigger_in),
        .veto(veto), .data_out(data_out), .busy(busy)
    );

    initial bus_clk = 1'b0;
    always #20 bus_clk = ~bus_clk;

    // galois lfsr, one step per bit
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] fe_expect(input int ch, input logic [15:0] d);
        return {1'b0, 4'(ch), 11'd0, d};
    endfunction

    function automatic logic [31:0] trig_expect(input int n);
        return {1'b1, 31'(n)};
    endfunction

    function automatic logic [15:0] ctrl_addr(input logic [7:0] off);
        return ADDR_CTRL + {8'h00, off};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge bus_clk);
        add     <= a;
        data_in <= d;
        wr      <= 1'b1;
        @(posedge bus_clk);
        wr <= 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        @(posedge bus_clk);
        add <= a;
        rd  <= 1'b1;
        @(posedge bus_clk);
        rd <= 1'b0;
        @(negedge bus_clk); // data_out registered on the edge above
        d = data_out;
    endtask

    task automatic read_word(output logic [31:0] w);
        logic [7:0] b;
        for (int i = 0; i < 4; i++) begin
            bus_read(ADDR_FIFO + 16'(i), b);
            w[8*i +: 8] = b; // low byte first
        end
    endtask

    task automatic read_trig_count(output logic [31:0] c);
        logic [7:0] b;
        for (int i = 0; i < 4; i++) begin
            bus_read(ctrl_addr(REG_TRIG_COUNT + 8'(i)), b);
            c[8*i +: 8] = b;
        end
    endtask

    task automatic fe_send(input int ch, input logic [15:0] d);
        @(posedge bus_clk);
        raw_strobe[ch] <= 1'b1;
        raw_data[ch]   <= d;
        @(posedge bus_clk);
        raw_strobe <= '0;
    endtask

    task automatic trigger_pulse();
        @(posedge bus_clk);
        trigger_in <= 1'b1;
        @(posedge bus_clk);
        trigger_in <= 1'b0;
    endtask

    task automatic wait_not_empty(output bit ok);
        logic [7:0] s;
        ok = 1'b0;
        for (int i = 0; i < 40 && !ok; i++) begin
            bus_read(ctrl_addr(REG_STATUS), s);
            ok = s[ST_NOT_EMPTY];
        end
        if (!ok) begin
            timeout_count++;
            $display("timeout: output FIFO stayed empty after 40 status polls");
        end
    endtask

    task automatic wait_busy_low();
        bit low;
        low = 1'b0;
        for (int i = 0; i < 20 && !low; i++) begin
            @(negedge bus_clk);
            low = !busy;
        end
        if (!low) begin
            timeout_count++;
            $display("timeout: busy stayed high for 20 cycles");
        end
    endtask

    // reads every expected word and compares
    task automatic drain_expected();
        logic [31:0] w;
        logic [31:0] exp;
        bit          ok;
        while (exp_q.size() > 0) begin
            wait_not_empty(ok);
            exp = exp_q.pop_front();
            if (ok) begin
                read_word(w);
                check_value("fifo word", exp, w);
            end
        end
    endtask

    task automatic reset_state();
        logic [7:0]  d;
        logic [31:0] c;
        bus_read(ctrl_addr(REG_CONTROL), d);
        check_value("control", 32'h0, d);
        bus_read(ctrl_addr(REG_STATUS), d);
        check_value("status", 32'h0, d);
        read_trig_count(c);
        check_value("trig_count", 32'h0, c);
        check_value("busy", 32'h0, busy);
    endtask

    task automatic fe_words();
        logic [15:0] p;
        logic [7:0]  s;
        bus_write(ctrl_addr(REG_CONTROL), 8'(1 << CTRL_FE_EN));
        for (int i = 0; i < 4; i++) begin
            for (int ch = 0; ch < NUM_FE; ch++) begin
                p = take_bits(16);
                fe_send(ch, p);
                exp_q.push_back(fe_expect(ch, p));
            end
        end
        drain_expected();
        bus_write(ctrl_addr(REG_CONTROL), 8'h00); // strobes now dropped
        fe_send(0, take_bits(16));
        fe_send(1, take_bits(16));
        repeat (4) @(posedge bus_clk);
        bus_read(ctrl_addr(REG_STATUS), s);
        check_value("status", 32'h0, s);
    endtask

    task automatic trigger_words();
        logic [15:0] p;
        logic [31:0] c;
        bus_write(ctrl_addr(REG_CONTROL), 8'((1 << CTRL_FE_EN) | (1 << CTRL_TRIG_EN)));
        for (int n = 1; n <= 3; n++) begin
            trigger_pulse();
            exp_q.push_back(trig_expect(n));
            if (n == 1) begin
                @(negedge bus_clk);
                check_value("busy", 32'h1, busy);
                wait_busy_low();
            end
        end
        drain_expected();
        read_trig_count(c);
        check_value("trig_count", 32'd3, c);

        // trigger and strobe on one edge
        p = take_bits(16);
        @(posedge bus_clk);
        trigger_in     <= 1'b1;
        raw_strobe[0]  <= 1'b1;
        raw_data[0]    <= p;
        @(posedge bus_clk);
        trigger_in <= 1'b0;
        raw_strobe <= '0;
        exp_q.push_back(trig_expect(4));
        exp_q.push_back(fe_expect(0, p));
        drain_expected();
        read_trig_count(c);
        check_value("trig_count", 32'd4, c);
    endtask

    task automatic veto_and_disable();
        logic [31:0] c;
        logic [7:0]  s;
        @(posedge bus_clk);
        veto <= 1'b1;
        trigger_pulse();
        @(posedge bus_clk);
        veto <= 1'b0;
        bus_write(ctrl_addr(REG_CONTROL), 8'(1 << CTRL_FE_EN)); // triggers off
        trigger_pulse();
        repeat (4) @(posedge bus_clk);
        read_trig_count(c);
        check_value("trig_count", 32'd4, c);
        bus_read(ctrl_addr(REG_STATUS), s);
        check_value("status", 32'h0, s);
        check_value("busy", 32'h0, busy);
    endtask

    task automatic read_error();
        logic [7:0] d;
        bus_read(ADDR_FIFO, d); // fifo is empty here
        check_value("fifo byte", 32'h0, d);
        bus_read(ctrl_addr(REG_STATUS), d);
        check_value("status", 32'(1 << ST_READ_ERR), d);
        bus_write(ctrl_addr(REG_STATUS), 8'h00);
        bus_read(ctrl_addr(REG_STATUS), d);
        check_value("status", 32'h0, d);
    endtask

    task automatic back_pressure();
        logic [15:0] p;
        logic [7:0]  s;
        // only channel 0, so arrival order equals send order
        for (int i = 0; i < OUT_NEAR_FULL + 4; i++) begin
            p = take_bits(16);
            fe_send(0, p);
            exp_q.push_back(fe_expect(0, p));
        end
        repeat (2) @(posedge bus_clk);
        bus_read(ctrl_addr(REG_STATUS), s);
        check_value("status near_full", 32'h1, s[ST_NEAR_FULL]);
        drain_expected();
        bus_read(ctrl_addr(REG_STATUS), s);
        check_value("status", 32'h0, s);
    endtask

    initial begin
        err_count     = 0;
        timeout_count = 0;
        check_count   = 0;
        lfsr          = 16'd36084;
        rst           = 1'b1;
        add           = '0;
        data_in       = '0;
        rd            = 1'b0;
        wr            = 1'b0;
        raw_strobe    = '0;
        raw_data      = '0;
        trigger_in    = 1'b0;
        veto          = 1'b0;
        repeat (4) @(posedge bus_clk);
        rst <= 1'b0;

        reset_state();
        fe_words();
        trigger_words();
        veto_and_disable();
        read_error();
        back_pressure();

        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count,
                 timeout_count);
        if (err_count == 0 && timeout_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: readout.f
src/readout_pkg.sv
src/sync_fifo.sv
src/fe_word_fifo.sv
src/trigger_word_gen.sv
src/word_arbiter.sv
src/out_fifo.sv
src/readout_ctrl.sv
src/readout_top.sv
dv/readout_assertions.sv
dv/readout_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the readout testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module readout_tb \
    -f readout.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vreadout_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "testbench reported failure"
    exit 1
fi
echo "simulation finished without failures"
exit 0
